/* include/fc_params.svh */
`ifndef FC_PARAMS_SVH
`define FC_PARAMS_SVH

// Node and weight word width
`define FC_DATA_W 8

// Accumulator and result width
`define FC_ACC_W 32

// Word address into the node and weight memories
`define FC_ADDR_W 12

// Vector length and step index
`define FC_CNT_W 12

// Number of parallel MAC lanes, one weight memory each
`define FC_NUM_CORE 4

`endif

/* hw/fc_ctrl_pkg.sv */
`include "fc_params.svh"

package fc_ctrl_pkg;

	// Phase state, shared by the read and write sides
	typedef enum logic [1:0] {
		PH_IDLE = 2'b00,
		PH_RUN  = 2'b01,
		PH_DONE = 2'b10
	} phase_state_t;

	// Vector length and step index
	typedef logic [`FC_CNT_W-1:0] cnt_t;

	// Memory word address
	typedef logic [`FC_ADDR_W-1:0] addr_t;

	// One read request, shared by node and weight memories
	typedef struct packed {
		addr_t addr;
		logic  ce;     // Chip enable
	} mem_req_t;

endpackage

/* hw/fc_data_pkg.sv */
`include "fc_params.svh"

package fc_data_pkg;

	// Signed node or weight word
	typedef logic signed [`FC_DATA_W-1:0] data_t;

	// Signed accumulator, also the result width
	typedef logic signed [`FC_ACC_W-1:0] acc_t;

	// One weight word per lane, lane k at index k
	typedef data_t [`FC_NUM_CORE-1:0] weight_vec_t;

	// One accumulated result per lane
	typedef acc_t [`FC_NUM_CORE-1:0] result_vec_t;

endpackage

/* hw/fc_phase_fsm.sv */
`timescale 1ns/1ps
`include "fc_params.svh"

module fc_phase_fsm (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      i_start,  // Run pulse, only seen in idle
	input  logic                      i_last,   // Last step of this phase
	output fc_ctrl_pkg::phase_state_t o_state,
	output logic                      o_active
);

	fc_ctrl_pkg::phase_state_t state;
	fc_ctrl_pkg::phase_state_t state_nxt;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= fc_ctrl_pkg::PH_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Idle -> run -> done -> idle
	always_comb begin
		state_nxt = state;
		case (state)
			fc_ctrl_pkg::PH_IDLE: begin
				if (i_start) begin
					state_nxt = fc_ctrl_pkg::PH_RUN;
				end
			end
			fc_ctrl_pkg::PH_RUN: begin
				if (i_last) begin
					state_nxt = fc_ctrl_pkg::PH_DONE;
				end
			end
			fc_ctrl_pkg::PH_DONE: begin
				state_nxt = fc_ctrl_pkg::PH_IDLE; // Done lasts one cycle
			end
			default: begin
				state_nxt = fc_ctrl_pkg::PH_IDLE; // Unused encoding
			end
		endcase
	end

	assign o_state  = state;
	assign o_active = (state == fc_ctrl_pkg::PH_RUN);

endmodule

/* hw/fc_step_counter.sv */
`timescale 1ns/1ps
`include "fc_params.svh"

module fc_step_counter (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              i_start,    // Capture length
	input  fc_ctrl_pkg::cnt_t i_num_cnt,  // Vector length, at least 1
	input  logic              i_en,       // One step this cycle
	output fc_ctrl_pkg::cnt_t o_cnt,
	output logic              o_last
);

	fc_ctrl_pkg::cnt_t num_cnt;  // Captured length
	fc_ctrl_pkg::cnt_t step_cnt;

	// Length register, cleared once the phase has used it
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			num_cnt <= '0;
		end else if (i_start) begin
			num_cnt <= i_num_cnt;
		end else if (o_last) begin
			num_cnt <= '0;
		end
	end

	// Enabled steps from zero, wrapping after the last one
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			step_cnt <= '0;
		end else if (i_start || o_last) begin
			step_cnt <= '0;
		end else if (i_en) begin
			step_cnt <= step_cnt + fc_ctrl_pkg::cnt_t'(1);
		end
	end

	// Combinational so the fsm leaves run on the next edge
	assign o_last = i_en && (step_cnt == num_cnt - fc_ctrl_pkg::cnt_t'(1));
	assign o_cnt  = step_cnt;

endmodule

/* hw/fc_mac_core.sv */
`timescale 1ns/1ps
`include "fc_params.svh"

module fc_mac_core (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               i_clear,   // Start of a new vector
	input  logic               i_valid,   // Node and weight words present
	input  fc_data_pkg::data_t i_node,
	input  fc_data_pkg::data_t i_weight,
	output fc_data_pkg::acc_t  o_acc,
	output logic               o_valid
);

	logic signed [2*`FC_DATA_W-1:0] prod;  // Full precision product
	fc_data_pkg::acc_t              acc;
	logic                           valid_q;

	assign prod = i_node * i_weight;

	// Running sum, wraps at the accumulator width
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			acc <= '0;
		end else if (i_clear) begin
			acc <= '0;
		end else if (i_valid) begin
			acc <= acc + fc_data_pkg::acc_t'(prod); // Sign extended
		end
	end

	// One cycle from input valid to output valid
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_valid;
		end
	end

	assign o_acc   = acc;
	assign o_valid = valid_q;

endmodule

/* hw/fc_layer_top.sv */
`timescale 1ns/1ps
`include "fc_params.svh"

module fc_layer_top (
	input  logic                     clk,
	input  logic                     reset_n,
	input  logic                     i_run,      // One-cycle pulse while idle
	input  fc_ctrl_pkg::cnt_t        i_num_cnt,  // Vector length N
	input  fc_data_pkg::data_t       i_node,     // Node memory read data
	input  fc_data_pkg::weight_vec_t i_weights,  // Weight memory read data
	output logic                     o_idle,
	output logic                     o_read,
	output logic                     o_write,
	output logic                     o_done,
	output fc_ctrl_pkg::mem_req_t    o_mem_req,
	output fc_data_pkg::result_vec_t o_results
);

	fc_ctrl_pkg::phase_state_t read_state;
	fc_ctrl_pkg::phase_state_t write_state;
	logic                      read_active;
	logic                      write_active;
	logic                      read_last;
	logic                      write_last;
	fc_ctrl_pkg::cnt_t         read_cnt;
	logic                      lane_in_valid;
	logic [`FC_NUM_CORE-1:0]   lane_valid;
	logic                      all_valid;

	// Read phase, one address per cycle
	fc_phase_fsm u_read_fsm (
		.clk      (clk),
		.reset_n  (reset_n),
		.i_start  (i_run),
		.i_last   (read_last),
		.o_state  (read_state),
		.o_active (read_active)
	);

	fc_step_counter u_read_cnt (
		.clk       (clk),
		.reset_n   (reset_n),
		.i_start   (i_run),
		.i_num_cnt (i_num_cnt),
		.i_en      (read_active),
		.o_cnt     (read_cnt),
		.o_last    (read_last)
	);

	// Write phase counts results that all lanes have produced
	fc_phase_fsm u_write_fsm (
		.clk      (clk),
		.reset_n  (reset_n),
		.i_start  (i_run),
		.i_last   (write_last),
		.o_state  (write_state),
		.o_active (write_active)
	);

	fc_step_counter u_write_cnt (
		.clk       (clk),
		.reset_n   (reset_n),
		.i_start   (i_run),
		.i_num_cnt (i_num_cnt),
		.i_en      (all_valid),
		.o_cnt     (),           // Only the last flag is needed here
		.o_last    (write_last)
	);

	// Shared request for the node and all weight memories
	assign o_mem_req.addr = fc_ctrl_pkg::addr_t'(read_cnt);
	assign o_mem_req.ce   = read_active;

	// Memory answers one cycle after the request
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			lane_in_valid <= 1'b0;
		end else begin
			lane_in_valid <= read_active;
		end
	end

	// Each lane sees the same node word and its own weight word
	for (genvar g = 0; g < `FC_NUM_CORE; g++) begin : g_lane
		fc_mac_core u_mac_core (
			.clk      (clk),
			.reset_n  (reset_n),
			.i_clear  (i_run),
			.i_valid  (lane_in_valid),
			.i_node   (i_node),
			.i_weight (i_weights[g]),
			.o_acc    (o_results[g]),
			.o_valid  (lane_valid[g])
		);
	end

	assign all_valid = &lane_valid;

	// Status
	assign o_idle  = (read_state == fc_ctrl_pkg::PH_IDLE) &&
	                 (write_state == fc_ctrl_pkg::PH_IDLE);
	assign o_read  = read_active;
	assign o_write = write_active;
	assign o_done  = (write_state == fc_ctrl_pkg::PH_DONE); // Write side ends last

endmodule

/* tests/fc_layer_props.sv */
`timescale 1ns/1ps

module fc_layer_props (
	input logic                  clk,
	input logic                  reset_n,
	input logic                  i_run,
	input logic                  i_idle,
	input logic                  i_read,
	input logic                  i_done,
	input fc_ctrl_pkg::mem_req_t i_mem_req
);

	int fail_count = 0;  // Read by the testbench at the end

	// Start only while both phases rest
	a_run_when_idle: assert property (@(posedge clk) disable iff (!reset_n)
		i_run |-> i_idle)
	else begin
		$error("i_run pulsed while the mover was busy");
		fail_count++;
	end

	// Done lasts one cycle, then back to idle
	a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		i_done |=> (!i_done && i_idle))
	else begin
		$error("o_done not a single pulse followed by idle");
		fail_count++;
	end

	// Reading starts at address zero the cycle after run
	a_read_start: assert property (@(posedge clk) disable iff (!reset_n)
		i_run |=> (i_mem_req.ce && i_read && (i_mem_req.addr == '0)))
	else begin
		$error("read did not start at address zero after i_run");
		fail_count++;
	end

endmodule

bind fc_layer_top fc_layer_props u_props (
	.clk       (clk),
	.reset_n   (reset_n),
	.i_run     (i_run),
	.i_idle    (o_idle),
	.i_read    (o_read),
	.i_done    (o_done),
	.i_mem_req (o_mem_req)
);

/* tests/fc_layer_tb.sv */
`timescale 1ns/1ps
`include "fc_params.svh"

module fc_layer_tb;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 5;
	localparam int MEM_DEPTH    = 1 << `FC_ADDR_W;
	localparam int NUM_ROWS     = 9;

	typedef enum logic [1:0] {
		FILL_ZERO,
		FILL_ONES,
		FILL_MAXNEG,
		FILL_RANDOM
	} fill_mode_t;

	// Length, data mode, cycles from run to done
	typedef struct packed {
		fc_ctrl_pkg::cnt_t n;
		fill_mode_t        mode;
		fc_ctrl_pkg::cnt_t done_cycles;
	} test_row_t;

	logic                     clk = 1'b0;
	logic                     reset_n;
	logic                     i_run;
	fc_ctrl_pkg::cnt_t        i_num_cnt;
	fc_data_pkg::data_t       i_node = '0;
	fc_data_pkg::weight_vec_t i_weights = '0;
	logic                     o_idle;
	logic                     o_read;
	logic                     o_write;
	logic                     o_done;
	fc_ctrl_pkg::mem_req_t    o_mem_req;
	fc_data_pkg::result_vec_t o_results;

	fc_data_pkg::data_t node_mem [MEM_DEPTH];
	fc_data_pkg::data_t weight_mem [`FC_NUM_CORE][MEM_DEPTH];
	fc_data_pkg::acc_t  expected [`FC_NUM_CORE];
	test_row_t          test_table [NUM_ROWS];
	integer             seed;
	logic               table_ready = 1'b0;
	logic               end_reported = 1'b0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	fc_layer_top uut (
		.clk       (clk),
		.reset_n   (reset_n),
		.i_run     (i_run),
		.i_num_cnt (i_num_cnt),
		.i_node    (i_node),
		.i_weights (i_weights),
		.o_idle    (o_idle),
		.o_read    (o_read),
		.o_write   (o_write),
		.o_done    (o_done),
		.o_mem_req (o_mem_req),
		.o_results (o_results)
	);

	// Node and weight memories, data one cycle after the request
	always @(posedge clk) begin
		if (o_mem_req.ce) begin
			i_node <= node_mem[o_mem_req.addr];
			for (int k = 0; k < `FC_NUM_CORE; k++) begin
				i_weights[k] <= weight_mem[k][o_mem_req.addr];
			end
		end
	end

	task automatic check_value(input logic [63:0] actual, input logic [63:0] exp_val,
	                           input string what);
		if (actual !== exp_val) begin
			end_reported = 1'b1;
			$display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, what, actual, exp_val);
			$display("Errors found");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic load_table();
		// Back-to-back rows change N so stale sums would show
		test_table[0] = '{12'd1,  FILL_RANDOM, 12'd4};
		test_table[1] = '{12'd1,  FILL_MAXNEG, 12'd4};
		test_table[2] = '{12'd4,  FILL_ZERO,   12'd7};
		test_table[3] = '{12'd8,  FILL_ONES,   12'd11};
		test_table[4] = '{12'd16, FILL_MAXNEG, 12'd19};
		test_table[5] = '{12'd5,  FILL_RANDOM, 12'd8};
		test_table[6] = '{12'd32, FILL_RANDOM, 12'd35};
		test_table[7] = '{12'd3,  FILL_RANDOM, 12'd6};
		test_table[8] = '{12'd64, FILL_MAXNEG, 12'd67};
	endtask

	function automatic fc_data_pkg::data_t make_word(input fill_mode_t mode);
		fc_data_pkg::data_t word;
		case (mode)
			FILL_ZERO:   word = '0;
			FILL_ONES:   word = '1;          // -1 as a signed word
			FILL_MAXNEG: word = 8'h80;
			default:     word = fc_data_pkg::data_t'($random(seed));
		endcase
		return word;
	endfunction

	// Words past the vector, so a wrong address gives a wrong sum
	function automatic fc_data_pkg::data_t fill_pattern(input int addr, input int mem_idx);
		return fc_data_pkg::data_t'(addr ^ (addr >> 5) ^ (addr >> 9) ^ (mem_idx * 37));
	endfunction

	task automatic fill_memories(input test_row_t row);
		for (int a = 0; a < MEM_DEPTH; a++) begin
			if (a < int'(row.n)) begin
				node_mem[a] = make_word(row.mode);
				for (int k = 0; k < `FC_NUM_CORE; k++) begin
					weight_mem[k][a] = make_word(row.mode);
				end
			end else begin
				node_mem[a] = fill_pattern(a, 0);
				for (int k = 0; k < `FC_NUM_CORE; k++) begin
					weight_mem[k][a] = fill_pattern(a, k + 1);
				end
			end
		end
	endtask

	// Signed dot product per lane, wrapping at the result width
	task automatic compute_expected(input fc_ctrl_pkg::cnt_t n);
		fc_data_pkg::acc_t prod;
		for (int k = 0; k < `FC_NUM_CORE; k++) begin
			expected[k] = '0;
			for (int i = 0; i < int'(n); i++) begin
				prod = fc_data_pkg::acc_t'(node_mem[i]) * fc_data_pkg::acc_t'(weight_mem[k][i]);
				expected[k] = expected[k] + prod;
			end
		end
	endtask

	task automatic check_reset_state();
		check_value(o_idle, 1'b1, "idle after reset");
		check_value(o_read, 1'b0, "read after reset");
		check_value(o_write, 1'b0, "write after reset");
		check_value(o_done, 1'b0, "done after reset");
		check_value(o_mem_req.ce, 1'b0, "chip enable after reset");
		for (int k = 0; k < `FC_NUM_CORE; k++) begin
			check_value(o_results[k], '0, $sformatf("lane %0d result after reset", k));
		end
	endtask

	task automatic run_row(input int r, input test_row_t row);
		int                 cyc;
		int                 read_cycles;
		int                 write_cycles;
		int                 first_read;
		int                 done_cyc;
		fc_ctrl_pkg::addr_t next_addr;
		@(posedge clk);
		#1;
		i_run = 1'b1;
		i_num_cnt = row.n;
		@(posedge clk);
		#1;
		i_run = 1'b0;
		i_num_cnt = '0;     // Length is only taken with the run pulse
		cyc = 0;
		read_cycles = 0;
		write_cycles = 0;
		first_read = 0;
		done_cyc = 0;
		next_addr = '0;
		// Cycle 1 is the first one after the run pulse
		while (done_cyc == 0) begin
			@(negedge clk);
			cyc++;
			check_value(o_mem_req.ce, cyc <= int'(row.n), $sformatf("row %0d chip enable", r));
			if (o_read) begin
				if (first_read == 0) begin
					first_read = cyc;
				end
				check_value(o_mem_req.addr, next_addr, $sformatf("row %0d read address", r));
				next_addr++;
				read_cycles++;
			end
			if (o_write) begin
				write_cycles++;
			end
			if (o_done) begin
				done_cyc = cyc;
			end
		end
		check_value(first_read, 1, $sformatf("row %0d first read cycle", r));
		check_value(read_cycles, row.n, $sformatf("row %0d read cycles", r));
		check_value(write_cycles, row.done_cycles - 1, $sformatf("row %0d write cycles", r));
		check_value(done_cyc, row.done_cycles, $sformatf("row %0d cycles to done", r));
		for (int k = 0; k < `FC_NUM_CORE; k++) begin
			check_value(o_results[k], expected[k], $sformatf("row %0d lane %0d sum", r, k));
		end
		@(negedge clk);
		check_value(o_done, 1'b0, $sformatf("row %0d done pulse width", r));
		check_value(o_idle, 1'b1, $sformatf("row %0d idle after done", r));
		for (int k = 0; k < `FC_NUM_CORE; k++) begin
			check_value(o_results[k], expected[k], $sformatf("row %0d lane %0d hold", r, k));
		end
	endtask

	initial begin
		seed = 32'h575c;
		reset_n = 1'b0;
		i_run = 1'b0;
		i_num_cnt = '0;
		load_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset_n = 1'b1;
		@(negedge clk);
		check_reset_state();
		for (int r = 0; r < NUM_ROWS; r++) begin
			fill_memories(test_table[r]);
			compute_expected(test_table[r].n);
			run_row(r, test_table[r]);
		end
		end_reported = 1'b1;
		if (uut.u_props.fail_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// Run length from the table, N+10 cycles per row
	initial begin
		int limit;
		limit = 20;
		wait (table_ready);
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit += int'(test_table[r].n) + 10;
		end
		#(limit * CLK_PERIOD);
		end_reported = 1'b1;
		$display("Timeout: the run did not finish within %0d clock cycles", limit);
		$display("Errors found");
		$fatal(1, "Watchdog expired");
	end

	final begin
		if (!end_reported) begin
			$display("Errors found");
		end
	end

endmodule

/* files.f */
+incdir+include
hw/fc_ctrl_pkg.sv
hw/fc_data_pkg.sv
hw/fc_phase_fsm.sv
hw/fc_step_counter.sv
hw/fc_mac_core.sv
hw/fc_layer_top.sv
tests/fc_layer_props.sv
tests/fc_layer_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module fc_layer_tb \
		-f files.f -o fc_layer_sim
	./obj_dir/fc_layer_sim | tee $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
